// File: design/aes_pkg.sv
//********************************************************************
// cipher-side types and constants for the AES-256 engine
// state bytes follow FIPS-197 column-major order
// byte i sits at row i%4, column i/4, and byte 0 is the MSB
// only the encrypt direction is covered
//********************************************************************
package aes_pkg;

    // AES-256 runs 14 rounds after the initial key add
    localparam int aes_rounds = 14;

    // 4x4 byte state
    localparam int state_bytes = 16;

    // full byte-wide table
    localparam int sbox_depth = 256;

    // x^8 = x^4 + x^3 + x + 1, folded back in by xtime
    localparam logic [7:0] gf_poly = 8'h1b;

    // b[0] is the leftmost byte on the bus (row 0, column 0)
    typedef struct packed {
        logic [0:state_bytes-1][7:0] b;
    } aes_state_t;

    // one 128-bit round key, same byte order as the state
    typedef logic [127:0] round_key_t;

    // round number 0..14, also the key ROM index
    typedef logic [3:0] round_idx_t;

endpackage

// File: design/aes_ctrl_pkg.sv
//********************************************************************
// host-side view of the engine
// one 128-bit bus word, meaning set by the 1-bit address
// only the start bit of the flags word does anything
//********************************************************************
package aes_ctrl_pkg;

    import aes_pkg::*;

    // host address codes
    localparam logic addr_flags = 1'b0;
    localparam logic addr_data  = 1'b1;

    // start sits in bit 0 of the word, the rest is spare
    typedef struct packed {
        logic [126:0] reserved;
        logic         start;
    } ctrl_flags_t;

    // same bus word, read as flags or as a plaintext block
    typedef union packed {
        ctrl_flags_t flags;
        aes_state_t  data;
    } host_word_u;

endpackage

// File: design/aes_sbox_rom.sv
//********************************************************************
// forward S-box table, one read per cycle
// data shows up one clock after the address
// table comes from design/aes_sbox.hex, path taken from the
// directory the simulator is started in
//********************************************************************
module aes_sbox_rom
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  logic [7:0] sbox_addr,
    output logic [7:0] sbox_data
);

    logic [7:0] table_mem [0:sbox_depth-1];

    // 16 bytes per line in the hex file
    initial
    begin
        $readmemh("design/aes_sbox.hex", table_mem);
    end

    // registered read, maps onto a block RAM
    always_ff @(posedge OK_addRK)
    begin
        sbox_data <= table_mem[sbox_addr];
    end

endmodule

// File: design/aes_key_rom.sv
//********************************************************************
// precomputed AES-256 round keys, 15 entries
// no key expansion on chip; a new key means a new hex file
// design/aes_round_keys.hex, one 128-bit key per line, key 0 first
// index 15 is never used and reads back undefined
//********************************************************************
module aes_key_rom
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  round_idx_t key_idx,
    output round_key_t round_key
);

    round_key_t key_mem [0:aes_rounds];

    initial
    begin
        $readmemh("design/aes_round_keys.hex", key_mem);
    end

    // one cycle from key_idx to round_key
    // the controller sets the index a full round ahead
    always_ff @(posedge OK_addRK)
    begin
        round_key <= key_mem[key_idx];
    end

endmodule

// File: design/aes_sub_shift.sv
//********************************************************************
// SubBytes and ShiftRows, one byte per clock through the S-box ROM
// sub_done pulses exactly 17 cycles after sub_start
// sub_start must not come again before sub_done
// sub_state holds until the next block is written over it
//********************************************************************
module aes_sub_shift
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  logic       sub_start,
    input  aes_state_t state,
    input  logic [7:0] sbox_data,
    output logic [7:0] sbox_addr,
    output logic       sub_done,
    output aes_state_t sub_state
);

    // ShiftRows target of a source byte
    // row r moves left by r, so the column drops by r mod 4
    function automatic logic [3:0] shift_dest(input logic [3:0] src);
        logic [1:0] row;
        logic [1:0] col;
        row = src[1:0];
        col = src[3:2] - row;
        return {col, row};
    endfunction

    aes_state_t in_state;
    logic       reading;
    logic [3:0] rd_cnt;
    logic [3:0] issue_idx;
    logic       rd_valid;
    logic [3:0] rd_idx;

    // byte 0 goes straight from the input port, saves a cycle
    assign issue_idx = sub_start ? 4'd0 : rd_cnt;
    assign sbox_addr = sub_start ? state.b[0] : in_state.b[rd_cnt];

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            reading  <= 1'b0;
            rd_cnt   <= '0;
            rd_valid <= 1'b0;
            rd_idx   <= '0;
            sub_done <= 1'b0;
        end
        else
        begin
            // rd_valid and rd_idx line up with the ROM output
            rd_valid <= sub_start || reading;
            rd_idx   <= issue_idx;
            // last byte lands on the same edge
            sub_done <= rd_valid && (rd_idx == 4'd15);
            if (sub_start)
            begin
                reading <= 1'b1;
                rd_cnt  <= 4'd1;
            end
            else if (reading)
            begin
                rd_cnt <= rd_cnt + 4'd1;
                if (rd_cnt == 4'd15)
                begin
                    reading <= 1'b0;
                end
            end
        end
    end

    // data path, no reset needed
    always_ff @(posedge OK_addRK)
    begin
        if (sub_start)
        begin
            in_state <= state;
        end
        if (rd_valid)
        begin
            sub_state.b[shift_dest(rd_idx)] <= sbox_data;
        end
    end

endmodule

// File: design/aes_mix_columns.sv
//********************************************************************
// MixColumns on all four columns in one registered step
// round must stay stable while sub_done is high
// final round (14) passes the state through, still one cycle
//********************************************************************
module aes_mix_columns
    import aes_pkg::*;
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  logic       sub_done,
    input  aes_state_t sub_state,
    input  round_idx_t round,
    output logic       mix_done,
    output aes_state_t mix_state
);

    // multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] v);
        return {v[6:0], 1'b0} ^ (v[7] ? gf_poly : 8'h00);
    endfunction

    // fixed matrix rows 2 3 1 1, rotated per output row
    function automatic aes_state_t mix_all(input aes_state_t s);
        aes_state_t m;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < state_bytes / 4; c++)
        begin
            a0 = s.b[4*c];
            a1 = s.b[4*c+1];
            a2 = s.b[4*c+2];
            a3 = s.b[4*c+3];
            // 3*a written as xtime(a) ^ a
            m.b[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            m.b[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            m.b[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            m.b[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return m;
    endfunction

    logic last_round;

    assign last_round = (round == round_idx_t'(aes_rounds));

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            mix_done <= 1'b0;
        end
        else
        begin
            mix_done <= sub_done;
        end
    end

    // result register
    always_ff @(posedge OK_addRK)
    begin
        if (sub_done)
        begin
            mix_state <= last_round ? sub_state : mix_all(sub_state);
        end
    end

endmodule

// File: design/aes_round_ctrl.sv
//********************************************************************
// host decode, round sequencing and AddRoundKey
// host writes are dropped while an encryption is running
// 2 cycles for round 0, then 19 per round, 268 to done in total
// enc_data and done change together, once per encryption
//********************************************************************
module aes_round_ctrl
    import aes_pkg::*;
    import aes_ctrl_pkg::*;
(
    input  logic        OK_addRK,
    input  logic        resetn,
    input  logic        wr,
    input  logic        addr,
    input  host_word_u  bus_word,
    input  logic        sub_done,
    input  aes_state_t  sub_state,
    input  logic        mix_done,
    input  aes_state_t  mix_state,
    input  round_key_t  round_key,
    output round_idx_t  key_idx,
    output logic        sub_start,
    output aes_state_t  state,
    output round_idx_t  round,
    output aes_state_t  enc_data,
    output logic        done
);

    // key0 waits on the ROM read, add0 does the initial XOR
    typedef enum logic [1:0] {ph_key0, ph_add0, ph_run} phase_t;

    ctrl_flags_t ctrl_reg;
    aes_state_t  plain;
    phase_t      phase;
    logic        busy;
    logic        take_start;
    logic        last_round;
    logic        load_state;
    aes_state_t  ark_in;
    aes_state_t  ark_out;

    // start bit stays set for the whole run
    assign busy       = ctrl_reg.start;
    assign take_start = wr && !busy && (addr == addr_flags) && bus_word.flags.start;
    assign last_round = (round == round_idx_t'(aes_rounds));

    // key for round r is fetched while round r runs
    assign key_idx = round;

    // AddRoundKey
    assign ark_in  = (phase == ph_add0) ? plain : mix_state;
    assign ark_out = aes_state_t'(ark_in ^ round_key);

    assign load_state = busy && ((phase == ph_add0) ||
                                 (phase == ph_run && mix_done && !last_round));

    // sub_done and sub_state are read only by mix_columns
    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            ctrl_reg  <= '0;
            phase     <= ph_key0;
            round     <= '0;
            sub_start <= 1'b0;
            done      <= 1'b0;
            enc_data  <= '0;
        end
        else
        begin
            sub_start <= 1'b0;
            if (take_start)
            begin
                ctrl_reg <= bus_word.flags;
                phase    <= ph_key0;
                round    <= '0;
                done     <= 1'b0;
            end
            else if (busy)
            begin
                case (phase)
                    ph_key0:
                    begin
                        phase <= ph_add0;
                    end
                    ph_add0:
                    begin
                        round     <= round_idx_t'(1);
                        sub_start <= 1'b1;
                        phase     <= ph_run;
                    end
                    ph_run:
                    begin
                        if (mix_done && last_round)
                        begin
                            enc_data       <= ark_out;
                            done           <= 1'b1;
                            ctrl_reg.start <= 1'b0;
                        end
                        else if (mix_done)
                        begin
                            round     <= round + round_idx_t'(1);
                            sub_start <= 1'b1;
                        end
                    end
                    default:
                    begin
                        phase <= ph_key0;
                    end
                endcase
            end
        end
    end

    // plaintext register, idle writes only
    always_ff @(posedge OK_addRK)
    begin
        if (wr && !busy && (addr == addr_data))
        begin
            plain <= bus_word.data;
        end
    end

    // round state fed to sub_shift
    always_ff @(posedge OK_addRK)
    begin
        if (load_state)
        begin
            state <= ark_out;
        end
    end

endmodule

// File: design/aes256_enc.sv
//********************************************************************
// AES-256 encryption engine, one block at a time
// fixed key from the round-key ROM, no key loading
// write plaintext at addr 1, then flags with start at addr 0
// done rises 268 clocks after the start write, with the ciphertext
//********************************************************************
module aes256_enc
    import aes_pkg::*;
    import aes_ctrl_pkg::*;
(
    input  logic       OK_addRK,
    input  logic       resetn,
    input  logic       wr,
    input  logic       addr,
    input  host_word_u bus_word,
    output aes_state_t enc_data,
    output logic       done
);

    // controller to round datapath
    round_idx_t key_idx;
    round_key_t round_key;
    logic       sub_start;
    aes_state_t state;
    round_idx_t round;

    // sub_shift and its ROM
    logic [7:0] sbox_addr;
    logic [7:0] sbox_data;
    logic       sub_done;
    aes_state_t sub_state;

    // mix stage back to the controller
    logic       mix_done;
    aes_state_t mix_state;

    aes_round_ctrl u_round_ctrl (
        .OK_addRK  (OK_addRK),
        .resetn    (resetn),
        .wr        (wr),
        .addr      (addr),
        .bus_word  (bus_word),
        .sub_done  (sub_done),
        .sub_state (sub_state),
        .mix_done  (mix_done),
        .mix_state (mix_state),
        .round_key (round_key),
        .key_idx   (key_idx),
        .sub_start (sub_start),
        .state     (state),
        .round     (round),
        .enc_data  (enc_data),
        .done      (done)
    );

    aes_sub_shift u_sub_shift (
        .OK_addRK  (OK_addRK),
        .resetn    (resetn),
        .sub_start (sub_start),
        .state     (state),
        .sbox_data (sbox_data),
        .sbox_addr (sbox_addr),
        .sub_done  (sub_done),
        .sub_state (sub_state)
    );

    aes_sbox_rom u_sbox_rom (
        .OK_addRK  (OK_addRK),
        .sbox_addr (sbox_addr),
        .sbox_data (sbox_data)
    );

    aes_key_rom u_key_rom (
        .OK_addRK  (OK_addRK),
        .key_idx   (key_idx),
        .round_key (round_key)
    );

    aes_mix_columns u_mix_columns (
        .OK_addRK  (OK_addRK),
        .resetn    (resetn),
        .sub_done  (sub_done),
        .sub_state (sub_state),
        .round     (round),
        .mix_done  (mix_done),
        .mix_state (mix_state)
    );

endmodule

// File: verif/aes256_enc_chk.sv
//********************************************************************
// assertion checker for the AES-256 engine, bound into aes256_enc
// expected ciphertext is the FIPS-197 AES-256 example only
// busy and timing are modeled from the host writes alone
// failed stays set once any assertion has fired
//********************************************************************
module aes256_enc_chk
    import aes_pkg::*;
    import aes_ctrl_pkg::*;
(
    input logic       OK_addRK,
    input logic       resetn,
    input logic       wr,
    input logic       addr,
    input host_word_u bus_word,
    input aes_state_t enc_data,
    input logic       done
);

    // 2 cycles for round 0, then 19 per round
    localparam int done_cycles = 2 + aes_rounds * 19;

    localparam logic [127:0] kat_plain  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] kat_cipher = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic         failed = 1'b0;
    logic         busy_m;
    logic         started;
    logic         kat_run;
    int           run_cnt;
    logic [127:0] last_plain;
    logic         accepted;

    // start write seen while the model is idle
    assign accepted = wr && !busy_m && (addr == addr_flags) && bus_word.flags.start;

    always_ff @(posedge OK_addRK)
    begin
        if (!resetn)
        begin
            busy_m     <= 1'b0;
            started    <= 1'b0;
            kat_run    <= 1'b0;
            run_cnt    <= 0;
            last_plain <= '0;
        end
        else
        begin
            // idle data writes only
            if (wr && !busy_m && (addr == addr_data))
            begin
                last_plain <= bus_word.data;
            end
            if (accepted)
            begin
                busy_m  <= 1'b1;
                started <= 1'b1;
                run_cnt <= 0;
                kat_run <= (last_plain == kat_plain);
            end
            else if (busy_m)
            begin
                run_cnt <= run_cnt + 1;
                // engine goes idle on the edge that raises done
                if (run_cnt == done_cycles - 1)
                begin
                    busy_m <= 1'b0;
                end
            end
        end
    end

    // quiet outputs until the first start
    a_reset_state: assert property (@(posedge OK_addRK) disable iff (!resetn)
        !started |-> !done && (enc_data == '0))
    else
    begin
        $error("error reset_state: expected done 0 enc_data 0, got done %b enc_data %h",
               done, enc_data);
        failed = 1'b1;
    end

    // low for the whole run
    a_done_low: assert property (@(posedge OK_addRK) disable iff (!resetn)
        busy_m |-> !done)
    else
    begin
        $error("error done_low: expected done 0, got %b", done);
        failed = 1'b1;
    end

    a_done_timing: assert property (@(posedge OK_addRK) disable iff (!resetn)
        $rose(done) |-> started && !busy_m && (run_cnt == done_cycles))
    else
    begin
        $error("error done_timing: expected %0d cycles, got %0d", done_cycles, run_cnt);
        failed = 1'b1;
    end

    a_done_hold: assert property (@(posedge OK_addRK) disable iff (!resetn)
        started && !busy_m |-> done)
    else
    begin
        $error("error done_hold: expected done 1, got %b", done);
        failed = 1'b1;
    end

    // result only moves with the rise of done
    a_enc_stable: assert property (@(posedge OK_addRK) disable iff (!resetn)
        !$rose(done) |-> $stable(enc_data))
    else
    begin
        $error("enc_data changed without done rising");
        failed = 1'b1;
    end

    a_kat: assert property (@(posedge OK_addRK) disable iff (!resetn)
        $rose(done) && kat_run |-> (enc_data == kat_cipher))
    else
    begin
        $error("error kat: expected %h, got %h", kat_cipher, enc_data);
        failed = 1'b1;
    end

endmodule

bind aes256_enc aes256_enc_chk u_chk (
    .OK_addRK (OK_addRK),
    .resetn   (resetn),
    .wr       (wr),
    .addr     (addr),
    .bus_word (bus_word),
    .enc_data (enc_data),
    .done     (done)
);

// File: verif/tb_aes256_enc.sv
//********************************************************************
// testbench for the AES-256 engine
// results are judged by the assertions bound in aes256_enc_chk
// known answer uses the FIPS-197 example key held in the key ROM
// random stimulus from $urandom, seed 45
//********************************************************************
module tb_aes256_enc
    import aes_pkg::*;
    import aes_ctrl_pkg::*;
();

    localparam int cycle_limit = 1000;
    localparam logic [127:0] kat_plain = 128'h00112233445566778899aabbccddeeff;

    logic       OK_addRK;
    logic       resetn;
    logic       wr;
    logic       addr;
    host_word_u bus_word;
    aes_state_t enc_data;
    logic       done;

    aes256_enc DUT (
        .OK_addRK (OK_addRK),
        .resetn   (resetn),
        .wr       (wr),
        .addr     (addr),
        .bus_word (bus_word),
        .enc_data (enc_data),
        .done     (done)
    );

    // period 100
    always #50 OK_addRK = ~OK_addRK;

    // stop at the first checker hit
    always @(negedge OK_addRK)
    begin
        if (DUT.u_chk.failed)
        begin
            $display("Verification failed");
            $fatal(1, "an assertion in aes256_enc_chk fired");
        end
    end

    function automatic logic [127:0] random_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic logic [127:0] flags_word(input logic start_bit, input logic [126:0] spare);
        ctrl_flags_t f;
        f.reserved = spare;
        f.start    = start_bit;
        return f;
    endfunction

    // one-cycle write strobe, driven on the falling edge
    task automatic host_write(input logic a, input logic [127:0] w);
        @(negedge OK_addRK);
        wr       = 1'b1;
        addr     = a;
        bus_word = w;
        @(negedge OK_addRK);
        wr = 1'b0;
    endtask

    task automatic start_block(input logic [127:0] plain);
        host_write(addr_data, plain);
        host_write(addr_flags, flags_word(1'b1, '0));
    endtask

    // junk writes, all well inside the busy window
    task automatic busy_writes(input int count);
        logic [127:0] junk;
        for (int i = 0; i < count; i++)
        begin
            repeat ($urandom_range(1, 20)) @(negedge OK_addRK);
            junk = random_block();
            if (i % 2 == 0)
            begin
                host_write(addr_data, junk);
            end
            else
            begin
                host_write(addr_flags, flags_word(1'b1, junk[126:0]));
            end
        end
    endtask

    task automatic wait_for_done(input string what);
        int n;
        n = 0;
        while (!done && n < cycle_limit)
        begin
            @(negedge OK_addRK);
            n++;
        end
        if (!done)
        begin
            $display("Verification failed");
            $fatal(1, "done never rose during the %s", what);
        end
    endtask

    initial
    begin
        logic [127:0] junk;
        OK_addRK = 1'b0;
        resetn   = 1'b0;
        wr       = 1'b0;
        addr     = 1'b0;
        bus_word = '0;
        void'($urandom(45));
        repeat (10) @(negedge OK_addRK);
        resetn = 1'b1;
        // flags write without start, engine stays idle
        repeat (3) @(negedge OK_addRK);
        junk = random_block();
        host_write(addr_flags, flags_word(1'b0, junk[126:0]));
        repeat (3) @(negedge OK_addRK);
        start_block(kat_plain);
        busy_writes(6);
        wait_for_done("known-answer block with busy writes");
        // restart on the plaintext already held
        // junk data writes from the busy window must not show here
        host_write(addr_flags, flags_word(1'b1, '0));
        wait_for_done("repeated known-answer block");
        repeat (5) @(negedge OK_addRK);
        start_block(random_block());
        busy_writes(4);
        wait_for_done("random block");
        repeat (3) @(negedge OK_addRK);
        #1;
        if (DUT.u_chk.failed)
        begin
            $display("Verification failed");
            $fatal(1, "an assertion in aes256_enc_chk fired");
        end
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: design/aes_sbox.hex
// forward AES S-box, 16 bytes per line, address 0x00 first
63 7c 77 7b f2 6b 6f c5 30 01 67 2b fe d7 ab 76
ca 82 c9 7d fa 59 47 f0 ad d4 a2 af 9c a4 72 c0
b7 fd 93 26 36 3f f7 cc 34 a5 e5 f1 71 d8 31 15
04 c7 23 c3 18 96 05 9a 07 12 80 e2 eb 27 b2 75
09 83 2c 1a 1b 6e 5a a0 52 3b d6 b3 29 e3 2f 84
53 d1 00 ed 20 fc b1 5b 6a cb be 39 4a 4c 58 cf
d0 ef aa fb 43 4d 33 85 45 f9 02 7f 50 3c 9f a8
51 a3 40 8f 92 9d 38 f5 bc b6 da 21 10 ff f3 d2
cd 0c 13 ec 5f 97 44 17 c4 a7 7e 3d 64 5d 19 73
60 81 4f dc 22 2a 90 88 46 ee b8 14 de 5e 0b db
e0 32 3a 0a 49 06 24 5c c2 d3 ac 62 91 95 e4 79
e7 c8 37 6d 8d d5 4e a9 6c 56 f4 ea 65 7a ae 08
ba 78 25 2e 1c a6 b4 c6 e8 dd 74 1f 4b bd 8b 8a
70 3e b5 66 48 03 f6 0e 61 35 57 b9 86 c1 1d 9e
e1 f8 98 11 69 d9 8e 94 9b 1e 87 e9 ce 55 28 df
8c a1 89 0d bf e6 42 68 41 99 2d 0f b0 54 bb 16

// File: design/aes_round_keys.hex
// AES-256 round keys 0 to 14, one 128-bit key per line, key 0 first
000102030405060708090a0b0c0d0e0f
101112131415161718191a1b1c1d1e1f
a573c29fa176c498a97fce93a572c09c
1651a8cd0244beda1a5da4c10640bade
ae87dff00ff11b68a68ed5fb03fc1567
6de1f1486fa54f9275f8eb5373b8518d
c656827fc9a799176f294cec6cd5598b
3de23a75524775e727bf9eb45407cf39
0bdc905fc27b0948ad5245a4c1871c2f
45f5a66017b2d387300d4d33640a820a
7ccff71cbeb4fe5413e6bbf0d261a7df
f01afafee7a82979d7a5644ab3afe640
2541fe719bf500258813bbd55a721c0a
4e5a6699a9f24fe07e572baacdf8cdea
24fc79ccbf0979e9371ac23c6d68de36

// File: flist.f
design/aes_pkg.sv
design/aes_ctrl_pkg.sv
design/aes_sbox_rom.sv
design/aes_key_rom.sv
design/aes_sub_shift.sv
design/aes_mix_columns.sv
design/aes_round_ctrl.sv
design/aes256_enc.sv
verif/aes256_enc_chk.sv
verif/tb_aes256_enc.sv

// File: run_sim.sh
#!/bin/sh
# build and run the AES-256 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_aes256_enc \
    -Mdir obj_dir -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_aes256_enc +verilator+error+limit+100 > sim.log 2>&1
status=$?

if grep -q "Verification failed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi

echo "simulation PASSED"
exit 0
